// ==== dv/lcd_ctrl_tb.sv ====
`default_nettype none

module lcd_ctrl_tb
    import lcd_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TICK_DIV   = 100;
    localparam int CLK_PERIOD = 10;
    localparam int NUM_WRITES = 40;
    localparam int MAX_GAP    = 32; // idle cycles before a write, exclusive.

    logic       i_clk;
    logic       i_rst_n;
    logic       i_wr;
    logic [6:0] i_addr;
    logic [7:0] i_char;
    logic       o_ready;
    logic       o_lcd_en;
    logic       o_lcd_rs;
    logic       o_lcd_rw;
    logic [7:0] o_lcd_data;

    integer     seed = 32'h6fe33360;

    // reference model of the bus traffic.
    lcd_word_t  exp_word [$];
    int         exp_wait [$];
    bit         exp_chain [$]; // issued right after the previous done.

    int         n_cap;
    int         n_accepted;
    int         cyc;
    int         prev_rise;
    int         en_len;
    logic       en_prev;
    lcd_word_t  rise_word;

    int         value_errs;
    int         protocol_errs;
    int         timeout_errs;

    lcd_ctrl_top #(
        .TICK_DIV (TICK_DIV)
    ) i_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr       (i_wr),
        .i_addr     (i_addr),
        .i_char     (i_char),
        .o_ready    (o_ready),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_rw   (o_lcd_rw),
        .o_lcd_data (o_lcd_data)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ceil(base / TICK_DIV), at least one cycle past the enable pulse.
    function automatic int scaled_wait(input int base);
        int q;
        q = (base + TICK_DIV - 1) / TICK_DIV;
        if (q < LCD_EN_CYCLES + 1) begin
            q = LCD_EN_CYCLES + 1;
        end
        return q;
    endfunction

    task automatic report_value(input string sig, input int expv, input int gotv);
        value_errs++;
        $display("Error at %0t: %s expected %0h, got %0h", $time, sig, expv, gotv);
    endtask

    task automatic print_counts();
        $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
                 value_errs, protocol_errs, timeout_errs);
    endtask

    task automatic push_expected(input lcd_word_t w, input int base, input bit chained);
        exp_word.push_back(w);
        exp_wait.push_back(scaled_wait(base));
        exp_chain.push_back(chained);
    endtask

    task automatic add_write(input logic [6:0] addr, input logic [7:0] chr);
        n_accepted++;
        push_expected('{rs: 1'b0, rw: 1'b0, data: {1'b1, addr}},
                      int'(LCD_BASE_WAIT[LCD_SET_ADDR]), 1'b0);
        push_expected('{rs: 1'b1, rw: 1'b0, data: chr},
                      int'(LCD_BASE_WAIT[LCD_WRITE_DATA]), 1'b1);
    endtask

    task automatic check_rise(input lcd_word_t cur);
        int gap;
        if (n_cap >= exp_word.size()) begin
            protocol_errs++;
            $display("Bus word %0h captured at %0t with no instruction pending", cur, $time);
        end
        else begin
            assert (cur.rs == exp_word[n_cap].rs)
                else report_value("o_lcd_rs", exp_word[n_cap].rs, cur.rs);
            assert (cur.rw == exp_word[n_cap].rw)
                else report_value("o_lcd_rw", exp_word[n_cap].rw, cur.rw);
            assert (cur.data == exp_word[n_cap].data)
                else report_value("o_lcd_data", exp_word[n_cap].data, cur.data);
            if (n_cap > 0) begin
                gap = cyc - prev_rise;
                if (exp_chain[n_cap]) begin
                    assert (gap == exp_wait[n_cap-1] + 3)
                        else report_value("o_lcd_en gap", exp_wait[n_cap-1] + 3, gap);
                end
                else begin
                    assert (gap >= exp_wait[n_cap-1] + 4) else begin
                        protocol_errs++;
                        $display("EN rose at %0t only %0d cycles after the previous one",
                                 $time, gap);
                    end
                end
            end
        end
        n_cap++;
        prev_rise = cyc;
        rise_word = cur;
    endtask

    // monitor runs on the falling edge, where every DUT output is settled.
    always @(negedge i_clk) begin
        lcd_word_t cur;
        logic      exp_ready;
        cyc++;
        cur = '{rs: o_lcd_rs, rw: o_lcd_rw, data: o_lcd_data};
        if (i_rst_n) begin
            // ready comes back two cycles after the last pending wait runs out.
            exp_ready = 1'b0;
            if (n_cap == exp_word.size()) begin
                exp_ready = (cyc - prev_rise >= exp_wait[n_cap-1] + 2);
            end
            assert (o_ready == exp_ready)
                else report_value("o_ready", exp_ready, o_ready);
            if (i_wr && o_ready) begin
                add_write(i_addr, i_char); // seen by the DUT on the next rising edge.
            end
            if (o_lcd_en && !en_prev) begin
                check_rise(cur);
                en_len = 1;
            end
            else if (o_lcd_en) begin
                en_len++;
                assert (cur == rise_word)
                    else report_value("bus word while EN high", rise_word, cur);
            end
            else if (en_prev) begin
                assert (en_len == LCD_EN_CYCLES)
                    else report_value("o_lcd_en width", LCD_EN_CYCLES, en_len);
            end
        end
        en_prev = o_lcd_en;
    end

    initial begin
        int limit_cyc;
        limit_cyc = 5 + 100;
        for (int k = 0; k < LCD_INIT_LEN; k++) begin
            limit_cyc += scaled_wait(int'(LCD_BASE_WAIT[k])) + 3;
        end
        limit_cyc += NUM_WRITES * (scaled_wait(int'(LCD_BASE_WAIT[LCD_SET_ADDR]))
                     + scaled_wait(int'(LCD_BASE_WAIT[LCD_WRITE_DATA])) + 8 + MAX_GAP + 2);
        #(limit_cyc * CLK_PERIOD);
        timeout_errs++;
        $display("Run did not finish within %0d cycles", limit_cyc);
        print_counts();
        $display("Checks failed");
        $finish;
    end

    initial begin
        int gap;
        i_clk   = 1'b0;
        i_rst_n = 1'b0;
        i_wr    = 1'b0;
        i_addr  = '0;
        i_char  = '0;
        en_prev = 1'b0;
        for (int k = 0; k < LCD_INIT_LEN; k++) begin
            push_expected(LCD_BASE_WORD[k], int'(LCD_BASE_WAIT[k]), k > 0);
        end
        repeat (5) @(posedge i_clk);
        i_rst_n <= 1'b1;

        // some writes land while ready is low and must be dropped.
        for (int n = 0; n < NUM_WRITES; n++) begin
            gap = $unsigned($random(seed)) % MAX_GAP;
            repeat (gap + 1) @(posedge i_clk);
            i_wr   <= 1'b1;
            i_addr <= 7'($random(seed));
            i_char <= 8'($random(seed));
            @(posedge i_clk);
            i_wr   <= 1'b0;
        end

        @(negedge i_clk);
        while (o_ready !== 1'b1) begin
            @(negedge i_clk);
        end
        repeat (10) @(posedge i_clk);
        assert (n_cap == exp_word.size())
            else report_value("bus word count", exp_word.size(), n_cap);
        assert (n_accepted > 0) else begin
            protocol_errs++;
            $display("No write was accepted during the run");
        end
        print_counts();
        if (value_errs + protocol_errs + timeout_errs == 0) begin
            $display("All checks passed");
        end
        else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/lcd_pkg.sv
src/lcd_cmd_if.sv
src/lcd_init_seq.sv
src/lcd_instr_decode.sv
src/lcd_instr_exec.sv
src/lcd_ctrl_top.sv
dv/lcd_ctrl_tb.sv

// ==== src/lcd_cmd_if.sv ====
`default_nettype none

interface lcd_cmd_if
    import lcd_pkg::*;
(
    input wire i_clk
);

    logic                  start;    // one-cycle request strobe.
    lcd_kind_e             kind;
    logic [7:0]            arg;
    lcd_word_t             word;
    logic [LCD_WAIT_W-1:0] wait_cyc;
    logic                  done;     // one-cycle finish strobe.

    modport seq (
        output start, kind, arg,
        input  done
    );

    modport dec (
        input  i_clk, start, kind, arg,
        output word, wait_cyc
    );

    modport exe (
        input  start, word, wait_cyc,
        output done
    );

endinterface

`default_nettype wire

// ==== src/lcd_ctrl_top.sv ====
`default_nettype none

module lcd_ctrl_top #(
    parameter int TICK_DIV = 1 // divides all execution times.
) (
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_wr,
    input  wire  [6:0] i_addr,
    input  wire  [7:0] i_char,
    output logic       o_ready,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic [7:0] o_lcd_data
);

    lcd_cmd_if u_cmd_if (
        .i_clk (i_clk)
    );

    // power-on program and write expansion.
    lcd_init_seq u_seq (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_wr    (i_wr),
        .i_addr  (i_addr),
        .i_char  (i_char),
        .o_ready (o_ready),
        .cmd     (u_cmd_if)
    );

    lcd_instr_decode #(
        .TICK_DIV (TICK_DIV)
    ) u_dec (
        .cmd (u_cmd_if)
    );

    // drives the LCD pins.
    lcd_instr_exec u_exec (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_rw   (o_lcd_rw),
        .o_lcd_data (o_lcd_data),
        .cmd        (u_cmd_if)
    );

endmodule

`default_nettype wire

// ==== src/lcd_init_seq.sv ====
`default_nettype none

module lcd_init_seq
    import lcd_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire        i_wr,
    input  wire  [6:0] i_addr,
    input  wire  [7:0] i_char,
    output logic       o_ready,
    lcd_cmd_if.seq     cmd
);

    localparam int STEP_W = $clog2(LCD_INIT_LEN);

    typedef enum logic [2:0] {
        S_BOOT,
        S_INIT,
        S_READY,
        S_ADDR,
        S_DATA
    } state_e;

    state_e            state_r, state_w;
    logic [STEP_W-1:0] step_r, step_w;
    logic              start_r, start_w;
    logic              ready_r, ready_w;
    lcd_kind_e         kind_r, kind_w;
    logic [7:0]        arg_r, arg_w;
    logic [7:0]        char_r, char_w;

    assign cmd.start = start_r;
    assign cmd.kind  = kind_r;
    assign cmd.arg   = arg_r;
    assign o_ready   = ready_r;

    always_comb begin
        state_w = state_r;
        step_w  = step_r;
        start_w = 1'b0;
        ready_w = ready_r;
        kind_w  = kind_r;
        arg_w   = arg_r;
        char_w  = char_r;
        case (state_r)
            S_BOOT: begin
                start_w = 1'b1;
                kind_w  = LCD_PRECHARGE;
                step_w  = '0;
                state_w = S_INIT;
            end
            S_INIT: begin
                if (cmd.done) begin
                    if (step_r == STEP_W'(LCD_INIT_LEN - 1)) begin
                        ready_w = 1'b1;
                        state_w = S_READY;
                    end
                    else begin
                        step_w  = step_r + 1'b1;
                        kind_w  = lcd_kind_e'(step_w); // init kinds follow the step.
                        start_w = 1'b1;
                    end
                end
            end
            S_READY: begin
                if (i_wr) begin
                    ready_w = 1'b0;
                    start_w = 1'b1;
                    kind_w  = LCD_SET_ADDR;
                    arg_w   = {1'b1, i_addr};
                    char_w  = i_char;
                    state_w = S_ADDR;
                end
            end
            S_ADDR: begin
                if (cmd.done) begin
                    start_w = 1'b1;
                    kind_w  = LCD_WRITE_DATA;
                    arg_w   = char_r;
                    state_w = S_DATA;
                end
            end
            S_DATA: begin
                if (cmd.done) begin
                    ready_w = 1'b1;
                    state_w = S_READY;
                end
            end
            default: begin
                state_w = S_BOOT;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= S_BOOT;
            step_r  <= '0;
            start_r <= 1'b0;
            ready_r <= 1'b0;
            kind_r  <= LCD_PRECHARGE;
            arg_r   <= '0;
        end
        else begin
            state_r <= state_w;
            step_r  <= step_w;
            start_r <= start_w;
            ready_r <= ready_w;
            kind_r  <= kind_w;
            arg_r   <= arg_w;
        end
    end

    always_ff @(posedge i_clk) begin
        char_r <= char_w;
    end

    // one instruction in flight at a time.
    a_one_in_flight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        cmd.start |=> (!cmd.start until_with cmd.done))
        else $error("start issued before done of previous instruction");

endmodule

`default_nettype wire

// ==== src/lcd_instr_decode.sv ====
`default_nettype none

module lcd_instr_decode
    import lcd_pkg::*;
#(
    parameter int TICK_DIV = 1
) (
    lcd_cmd_if.dec cmd
);

    if (TICK_DIV < 1) begin : g_bad_div
        $error("TICK_DIV must be at least 1");
    end

    // ceil(base / TICK_DIV), never shorter than the enable pulse plus one.
    function automatic logic [LCD_WAIT_W-1:0] scale_wait(input logic [LCD_WAIT_W-1:0] base);
        int unsigned q;
        q = (32'(base) + TICK_DIV - 1) / TICK_DIV;
        if (q < LCD_WAIT_MIN) begin
            q = LCD_WAIT_MIN;
        end
        return LCD_WAIT_W'(q);
    endfunction

    logic [LCD_WAIT_W-1:0] wait_tab [LCD_KIND_NUM];
    lcd_word_t             word_c;

    // folded to constants at elaboration.
    for (genvar k = 0; k < LCD_KIND_NUM; k++) begin : g_wait
        assign wait_tab[k] = scale_wait(LCD_BASE_WAIT[k]);
    end

    always_comb begin
        word_c = LCD_BASE_WORD[cmd.kind];
        case (cmd.kind)
            LCD_SET_ADDR: begin
                word_c.data[6:0] = cmd.arg[6:0]; // bit 7 is the opcode.
            end
            LCD_WRITE_DATA: begin
                word_c.rs   = 1'b1;
                word_c.data = cmd.arg;
            end
            default: begin
            end
        endcase
    end

    assign cmd.word     = word_c;
    assign cmd.wait_cyc = wait_tab[cmd.kind];

    // the word and wait tables cover only the defined kinds.
    a_kind_legal: assert property (@(posedge cmd.i_clk)
        cmd.start |-> int'(cmd.kind) < LCD_KIND_NUM)
        else $error("undefined instruction kind %0d", cmd.kind);

endmodule

`default_nettype wire

// ==== src/lcd_instr_exec.sv ====
`default_nettype none

module lcd_instr_exec
    import lcd_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic [7:0] o_lcd_data,
    lcd_cmd_if.exe     cmd
);

    typedef enum logic {
        S_IDLE = 1'b0,
        S_EXE  = 1'b1
    } state_e;

    state_e                state_r, state_w;
    lcd_word_t             word_r, word_w;
    logic [LCD_WAIT_W-1:0] cnt_r, cnt_w;
    logic [LCD_WAIT_W-1:0] wait_r;
    logic                  en_r, en_w;
    logic                  done_r, done_w;

    assign o_lcd_en   = en_r;
    assign o_lcd_rs   = word_r.rs;
    assign o_lcd_rw   = word_r.rw;
    assign o_lcd_data = word_r.data;
    assign cmd.done   = done_r;

    always_comb begin
        state_w = state_r;
        word_w  = word_r;
        cnt_w   = cnt_r;
        en_w    = 1'b0;
        done_w  = 1'b0;
        case (state_r)
            S_IDLE: begin
                if (cmd.start) begin
                    state_w = S_EXE;
                    word_w  = cmd.word;
                    cnt_w   = '0;
                    en_w    = 1'b1;
                end
            end
            S_EXE: begin
                if (cnt_r == wait_r) begin
                    state_w = S_IDLE;
                    done_w  = 1'b1;
                end
                else begin
                    cnt_w = cnt_r + 1'b1;
                end
                // EN covers the first LCD_EN_CYCLES cycles.
                en_w = (cnt_r < LCD_WAIT_W'(LCD_EN_CYCLES - 1));
            end
            default: begin
                state_w = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= S_IDLE;
            word_r  <= '0; // bus lines idle low.
            cnt_r   <= '0;
            en_r    <= 1'b0;
            done_r  <= 1'b0;
        end
        else begin
            state_r <= state_w;
            word_r  <= word_w;
            cnt_r   <= cnt_w;
            en_r    <= en_w;
            done_r  <= done_w;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_r == S_IDLE && cmd.start) begin
            wait_r <= cmd.wait_cyc;
        end
    end

    a_word_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_lcd_en && $past(o_lcd_en) |-> $stable(word_r))
        else $error("bus word changed while EN high");

    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        cmd.done |=> !cmd.done)
        else $error("done held for more than one cycle");

endmodule

`default_nettype wire

// ==== src/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    // power-on kinds come first and in program order.
    typedef enum logic [2:0] {
        LCD_PRECHARGE  = 3'd0,
        LCD_FUNC_SET   = 3'd1,
        LCD_DISP_ON    = 3'd2,
        LCD_CLEAR      = 3'd3,
        LCD_ENTRY_MODE = 3'd4,
        LCD_SET_ADDR   = 3'd5,
        LCD_WRITE_DATA = 3'd6
    } lcd_kind_e;

    localparam int LCD_KIND_NUM = 7;

    typedef struct packed {
        logic       rs;
        logic       rw;
        logic [7:0] data;
    } lcd_word_t;

    localparam int LCD_WAIT_W    = 15;
    localparam int LCD_EN_CYCLES = 2;
    localparam int LCD_WAIT_MIN  = LCD_EN_CYCLES + 1; // EN must fall before done.
    localparam int LCD_INIT_LEN  = 5;

    localparam lcd_word_t LCD_BASE_WORD [LCD_KIND_NUM] = '{
        '{rs: 1'b0, rw: 1'b0, data: 8'b0011_0000}, // 8-bit bus wake-up.
        '{rs: 1'b0, rw: 1'b0, data: 8'b0011_1000}, // 8-bit, 2 lines, 5x8.
        '{rs: 1'b0, rw: 1'b0, data: 8'b0000_1100}, // display on, no cursor.
        '{rs: 1'b0, rw: 1'b0, data: 8'b0000_0001},
        '{rs: 1'b0, rw: 1'b0, data: 8'b0000_0110}, // increment, no shift.
        '{rs: 1'b0, rw: 1'b0, data: 8'b1000_0000}, // low 7 bits from arg.
        '{rs: 1'b0, rw: 1'b0, data: 8'b0000_0000}  // whole byte from arg.
    };

    // execution times in clocks at full speed.
    localparam logic [LCD_WAIT_W-1:0] LCD_BASE_WAIT [LCD_KIND_NUM] = '{
        15'd15000,
        15'd39,
        15'd39,
        15'd1530,
        15'd39,
        15'd39,
        15'd43
    };

endpackage

`default_nettype wire
